// File: camera.sv
module camera #(
    parameter int frame_width  = 16,
    parameter int frame_height = 8,
    parameter int crop_width   = 8,
    parameter int crop_height  = 4
) (
    input  logic        mipi_byte_clock,
    input  logic        mipi_byte_reset_n,
    input  logic [7:0]  mipi_byte_i,
    input  logic        mipi_byte_valid_i,
    input  logic [11:0] axi_awaddr_i,
    input  logic        axi_awvalid_i,
    output logic        axi_awready_o,
    input  logic [31:0] axi_wdata_i,
    input  logic [3:0]  axi_wstrb_i,
    input  logic        axi_wvalid_i,
    output logic        axi_wready_o,
    output logic [1:0]  axi_bresp_o,
    output logic        axi_bvalid_o,
    input  logic        axi_bready_i,
    input  logic [11:0] axi_araddr_i,
    input  logic        axi_arvalid_i,
    output logic        axi_arready_o,
    output logic [31:0] axi_rdata_o,
    output logic [1:0]  axi_rresp_o,
    output logic        axi_rvalid_o,
    input  logic        axi_rready_i
);
    import camera_pkg::*;

    localparam int addr_w = $clog2(crop_width * crop_height);

    logic              frame_start;
    logic              frame_end;
    logic              line_start;
    logic [7:0]        pixel;
    logic              pixel_valid;
    frame_number_t     frame_number;
    logic [15:0]       origin_x;
    logic [15:0]       origin_y;
    logic              buf_wr;
    logic [addr_w-1:0] buf_addr;
    logic [7:0]        buf_data;
    logic              window_done;
    logic [7:0]        mean;
    logic [7:0]        peak;
    logic              metering_valid;

    csi2_packet_parser u_parser (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .mipi_byte_i       (mipi_byte_i),
        .mipi_byte_valid_i (mipi_byte_valid_i),
        .frame_start_o     (frame_start),
        .frame_end_o       (frame_end),
        .line_start_o      (line_start),
        .pixel_o           (pixel),
        .pixel_valid_o     (pixel_valid),
        .frame_number_o    (frame_number)
    );

    // Pan crop into the capture buffer
    window_crop #(
        .crop_width  (crop_width),
        .crop_height (crop_height)
    ) u_crop (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_start_i     (frame_start),
        .line_start_i      (line_start),
        .frame_end_i       (frame_end),
        .pixel_i           (pixel),
        .pixel_valid_i     (pixel_valid),
        .origin_x_i        (origin_x),
        .origin_y_i        (origin_y),
        .buf_wr_o          (buf_wr),
        .buf_addr_o        (buf_addr),
        .buf_data_o        (buf_data),
        .window_done_o     (window_done)
    );

    // Meters the full frame, not the window
    exposure_metering #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) u_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_start_i     (frame_start),
        .frame_end_i       (frame_end),
        .pixel_i           (pixel),
        .pixel_valid_i     (pixel_valid),
        .mean_o            (mean),
        .peak_o            (peak),
        .metering_valid_o  (metering_valid)
    );

    camera_registers #(
        .crop_width  (crop_width),
        .crop_height (crop_height)
    ) u_registers (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .axi_awaddr_i      (axi_awaddr_i),
        .axi_awvalid_i     (axi_awvalid_i),
        .axi_awready_o     (axi_awready_o),
        .axi_wdata_i       (axi_wdata_i),
        .axi_wstrb_i       (axi_wstrb_i),
        .axi_wvalid_i      (axi_wvalid_i),
        .axi_wready_o      (axi_wready_o),
        .axi_bresp_o       (axi_bresp_o),
        .axi_bvalid_o      (axi_bvalid_o),
        .axi_bready_i      (axi_bready_i),
        .axi_araddr_i      (axi_araddr_i),
        .axi_arvalid_i     (axi_arvalid_i),
        .axi_arready_o     (axi_arready_o),
        .axi_rdata_o       (axi_rdata_o),
        .axi_rresp_o       (axi_rresp_o),
        .axi_rvalid_o      (axi_rvalid_o),
        .axi_rready_i      (axi_rready_i),
        .buf_wr_i          (buf_wr),
        .buf_addr_i        (buf_addr),
        .buf_data_i        (buf_data),
        .window_done_i     (window_done),
        .mean_i            (mean),
        .peak_i            (peak),
        .metering_valid_i  (metering_valid),
        .frame_number_i    (frame_number),
        .origin_x_o        (origin_x),
        .origin_y_o        (origin_y)
    );

endmodule

// File: camera_pkg.sv
package camera_pkg;

    // CSI-2 data type codes
    localparam logic [5:0] dt_frame_start = 6'h00;
    localparam logic [5:0] dt_frame_end   = 6'h01;
    localparam logic [5:0] dt_raw8        = 6'h2A;

    typedef logic [15:0] frame_number_t;

    // Packet header as received with byte 0 in bits 7:0
    typedef union packed {
        struct packed {
            logic [7:0]  ecc;
            logic [15:0] word_count;       // Payload bytes sent little endian
            logic [1:0]  virtual_channel;
            logic [5:0]  data_type;
        } long_pkt;
        struct packed {
            logic [7:0]    ecc;
            frame_number_t frame_number;   // Frame or line number
            logic [1:0]    virtual_channel;
            logic [5:0]    data_type;
        } short_pkt;
    } csi2_header_t;

    // AXI4-Lite byte offsets
    localparam logic [11:0] reg_control     = 12'h000;
    localparam logic [11:0] reg_origin      = 12'h004;
    localparam logic [11:0] reg_metering    = 12'h008;
    localparam logic [11:0] reg_buffer_base = 12'h100;

endpackage

// File: camera_registers.sv
module camera_registers #(
    parameter  int crop_width  = 8,
    parameter  int crop_height = 4,
    localparam int buf_depth   = crop_width * crop_height,
    localparam int addr_w      = $clog2(buf_depth)
) (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  logic [11:0]               axi_awaddr_i,
    input  logic                      axi_awvalid_i,
    output logic                      axi_awready_o,
    input  logic [31:0]               axi_wdata_i,
    input  logic [3:0]                axi_wstrb_i,
    input  logic                      axi_wvalid_i,
    output logic                      axi_wready_o,
    output logic [1:0]                axi_bresp_o,
    output logic                      axi_bvalid_o,
    input  logic                      axi_bready_i,
    input  logic [11:0]               axi_araddr_i,
    input  logic                      axi_arvalid_i,
    output logic                      axi_arready_o,
    output logic [31:0]               axi_rdata_o,
    output logic [1:0]                axi_rresp_o,
    output logic                      axi_rvalid_o,
    input  logic                      axi_rready_i,
    input  logic                      buf_wr_i,
    input  logic [addr_w-1:0]         buf_addr_i,
    input  logic [7:0]                buf_data_i,
    input  logic                      window_done_i,
    input  logic [7:0]                mean_i,
    input  logic [7:0]                peak_i,
    input  logic                      metering_valid_i,
    input  camera_pkg::frame_number_t frame_number_i,
    output logic [15:0]               origin_x_o,
    output logic [15:0]               origin_y_o
);
    import camera_pkg::*;

    logic        wr_en;
    logic        rd_en;
    logic        arm;
    logic        done;
    logic [31:0] origin_q;
    logic [7:0]  mean_q;
    logic [7:0]  peak_q;
    logic [11:0] buf_offset;
    logic        buf_hit;
    logic [31:0] read_word;
    logic [7:0]  capture_buf [buf_depth];

    // Ready only while no response is outstanding
    assign wr_en         = axi_awvalid_i && axi_wvalid_i && !axi_bvalid_o;
    assign axi_awready_o = wr_en;
    assign axi_wready_o  = wr_en;
    assign rd_en         = axi_arvalid_i && !axi_rvalid_o;
    assign axi_arready_o = rd_en;
    assign axi_bresp_o   = 2'b00;
    assign axi_rresp_o   = 2'b00;

    assign origin_x_o = origin_q[15:0];
    assign origin_y_o = origin_q[31:16];

    assign buf_offset = axi_araddr_i - reg_buffer_base;
    assign buf_hit    = (axi_araddr_i >= reg_buffer_base) && (buf_offset < 12'(4 * buf_depth));

    always_comb begin
        read_word = '0;
        if (buf_hit) begin
            read_word = {24'h0, capture_buf[buf_offset[addr_w+1:2]]};   // One pixel per word
        end else begin
            case (axi_araddr_i)
                reg_control:  read_word = {frame_number_i, 14'h0, done, arm};
                reg_origin:   read_word = origin_q;
                reg_metering: read_word = {16'h0, peak_q, mean_q};
                default:      read_word = '0;
            endcase
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            axi_bvalid_o <= 1'b0;
            axi_rvalid_o <= 1'b0;
            arm          <= 1'b0;
            done         <= 1'b0;
            origin_q     <= '0;
            mean_q       <= '0;
            peak_q       <= '0;
        end else begin
            if (wr_en) begin
                axi_bvalid_o <= 1'b1;
            end else if (axi_bready_i) begin
                axi_bvalid_o <= 1'b0;
            end
            if (rd_en) begin
                axi_rvalid_o <= 1'b1;
            end else if (axi_rready_i) begin
                axi_rvalid_o <= 1'b0;
            end
            if (metering_valid_i) begin
                mean_q <= mean_i;
                peak_q <= peak_i;
            end
            if (window_done_i && arm) begin   // Capture complete
                arm  <= 1'b0;
                done <= 1'b1;
            end
            if (wr_en && axi_awaddr_i == reg_control && axi_wstrb_i[0]) begin
                arm <= axi_wdata_i[0];
                if (axi_wdata_i[0]) begin
                    done <= 1'b0;
                end
            end
            if (wr_en && axi_awaddr_i == reg_origin) begin
                for (int i = 0; i < 4; i++) begin
                    if (axi_wstrb_i[i]) begin
                        origin_q[8*i +: 8] <= axi_wdata_i[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (buf_wr_i && arm) begin
            capture_buf[buf_addr_i] <= buf_data_i;
        end
        if (rd_en) begin
            axi_rdata_o <= read_word;
        end
    end

    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        axi_bvalid_o && !axi_bready_i |=> axi_bvalid_o);

    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        axi_rvalid_o && !axi_rready_i |=> axi_rvalid_o && $stable(axi_rdata_o));

endmodule

// File: csi2_packet_parser.sv
module csi2_packet_parser (
    input  logic                      mipi_byte_clock,
    input  logic                      mipi_byte_reset_n,
    input  logic [7:0]                mipi_byte_i,
    input  logic                      mipi_byte_valid_i,
    output logic                      frame_start_o,
    output logic                      frame_end_o,
    output logic                      line_start_o,
    output logic [7:0]                pixel_o,
    output logic                      pixel_valid_o,
    output camera_pkg::frame_number_t frame_number_o
);
    import camera_pkg::*;

    localparam logic [1:0] st_header  = 2'd0;
    localparam logic [1:0] st_payload = 2'd1;
    localparam logic [1:0] st_drop    = 2'd2;   // CRC, other payloads, idle tail

    logic [1:0]   state;
    logic [1:0]   hdr_count;
    logic [15:0]  remaining;
    csi2_header_t header;
    csi2_header_t next_header;

    // Incoming byte lands on top, so byte 0 ends up in bits 7:0
    assign next_header = {mipi_byte_i, header[31:8]};

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state          <= st_header;
            hdr_count      <= '0;
            remaining      <= '0;
            header         <= '0;
            frame_start_o  <= 1'b0;
            frame_end_o    <= 1'b0;
            line_start_o   <= 1'b0;
            pixel_valid_o  <= 1'b0;
            frame_number_o <= '0;
        end else begin
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            line_start_o  <= 1'b0;
            pixel_valid_o <= 1'b0;
            if (!mipi_byte_valid_i) begin
                state     <= st_header;   // LP-11 between packets
                hdr_count <= '0;
            end else begin
                case (state)
                    st_header: begin
                        header    <= next_header;
                        hdr_count <= hdr_count + 2'd1;
                        if (hdr_count == 2'd3) begin
                            state <= st_drop;
                            if (next_header.short_pkt.data_type == dt_frame_start) begin
                                frame_start_o  <= 1'b1;
                                frame_number_o <= next_header.short_pkt.frame_number;
                            end else if (next_header.short_pkt.data_type == dt_frame_end) begin
                                frame_end_o <= 1'b1;
                            end else if (next_header.long_pkt.data_type == dt_raw8 &&
                                         next_header.long_pkt.word_count != '0) begin
                                line_start_o <= 1'b1;
                                remaining    <= next_header.long_pkt.word_count;
                                state        <= st_payload;
                            end
                        end
                    end
                    st_payload: begin
                        pixel_valid_o <= 1'b1;
                        remaining     <= remaining - 16'd1;
                        if (remaining == 16'd1) begin
                            state <= st_drop;   // Two CRC bytes follow
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (state == st_payload) begin
            pixel_o <= mipi_byte_i;
        end
    end

    // A pixel only ever comes from the payload of a RAW8 long packet
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        pixel_valid_o |-> $past(state == st_payload && mipi_byte_valid_i &&
                                header.long_pkt.data_type == dt_raw8));

endmodule

// File: exposure_metering.sv
module exposure_metering #(
    parameter  int frame_width  = 16,
    parameter  int frame_height = 8,
    localparam int mean_shift   = $clog2(frame_width * frame_height),
    localparam int sum_w        = mean_shift + 8
) (
    input  logic       mipi_byte_clock,
    input  logic       mipi_byte_reset_n,
    input  logic       frame_start_i,
    input  logic       frame_end_i,
    input  logic [7:0] pixel_i,
    input  logic       pixel_valid_i,
    output logic [7:0] mean_o,
    output logic [7:0] peak_o,
    output logic       metering_valid_o
);

    logic [sum_w-1:0] sum;
    logic [7:0]       peak;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            sum              <= '0;
            peak             <= '0;
            metering_valid_o <= 1'b0;
        end else begin
            metering_valid_o <= frame_end_i;
            if (frame_start_i) begin
                sum  <= '0;
                peak <= '0;
            end else if (pixel_valid_i) begin
                sum <= sum + sum_w'(pixel_i);
                if (pixel_i > peak) begin
                    peak <= pixel_i;
                end
            end
        end
    end

    // Pixel count is a power of two, so the mean is a plain shift
    always_ff @(posedge mipi_byte_clock) begin
        if (frame_end_i) begin
            mean_o <= 8'(sum >> mean_shift);
            peak_o <= peak;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_camera -f src.f
./obj_dir/Vtb_camera | tee sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

// File: src.f
camera_pkg.sv
csi2_packet_parser.sv
window_crop.sv
exposure_metering.sv
camera_registers.sv
camera.sv
tb_clock_gen.sv
tb_camera.sv

// File: tb_camera.sv
module tb_camera;
    timeunit 1ns;
    timeprecision 1ns;
    import camera_pkg::*;

    localparam int frame_width  = 16;
    localparam int frame_height = 8;
    localparam int crop_width   = 8;
    localparam int crop_height  = 4;
    localparam int buf_depth    = crop_width * crop_height;
    localparam int handshake_limit = 20;   // Cycles per AXI handshake
    localparam int poll_limit      = 50;   // Status reads before giving up

    logic        mipi_byte_clock;
    logic        mipi_byte_reset_n;
    logic [7:0]  mipi_byte_i;
    logic        mipi_byte_valid_i;
    logic [11:0] axi_awaddr_i;
    logic        axi_awvalid_i;
    logic        axi_awready_o;
    logic [31:0] axi_wdata_i;
    logic [3:0]  axi_wstrb_i;
    logic        axi_wvalid_i;
    logic        axi_wready_o;
    logic [1:0]  axi_bresp_o;
    logic        axi_bvalid_o;
    logic        axi_bready_i;
    logic [11:0] axi_araddr_i;
    logic        axi_arvalid_i;
    logic        axi_arready_o;
    logic [31:0] axi_rdata_o;
    logic [1:0]  axi_rresp_o;
    logic        axi_rvalid_o;
    logic        axi_rready_i;

    integer      seed = 32'habe0_1b61;
    int          check_count = 0;
    int          error_count = 0;
    logic [7:0]  frame_pix [frame_height][frame_width];
    logic [31:0] first_crop [buf_depth];   // Buffer content after the armed frame

    tb_clock_gen #(
        .reset_cycles (8)
    ) u_clock_gen (
        .mipi_byte_clock_o   (mipi_byte_clock),
        .mipi_byte_reset_n_o (mipi_byte_reset_n)
    );

    camera #(
        .frame_width  (frame_width),
        .frame_height (frame_height),
        .crop_width   (crop_width),
        .crop_height  (crop_height)
    ) u_dut (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .mipi_byte_i       (mipi_byte_i),
        .mipi_byte_valid_i (mipi_byte_valid_i),
        .axi_awaddr_i      (axi_awaddr_i),
        .axi_awvalid_i     (axi_awvalid_i),
        .axi_awready_o     (axi_awready_o),
        .axi_wdata_i       (axi_wdata_i),
        .axi_wstrb_i       (axi_wstrb_i),
        .axi_wvalid_i      (axi_wvalid_i),
        .axi_wready_o      (axi_wready_o),
        .axi_bresp_o       (axi_bresp_o),
        .axi_bvalid_o      (axi_bvalid_o),
        .axi_bready_i      (axi_bready_i),
        .axi_araddr_i      (axi_araddr_i),
        .axi_arvalid_i     (axi_arvalid_i),
        .axi_arready_o     (axi_arready_o),
        .axi_rdata_o       (axi_rdata_o),
        .axi_rresp_o       (axi_rresp_o),
        .axi_rvalid_o      (axi_rvalid_o),
        .axi_rready_i      (axi_rready_i)
    );

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s (got %h, expected %h)", $time, what, actual, expected);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t ns: no response while waiting for %s", $time, what);
        $display("Checks run: %0d, errors: %0d, timeouts: 1", check_count, error_count);
        $display("Checks failed");
        $finish;
    endtask

    // Crop window is row major with the origin in pixels
    function automatic logic [31:0] ref_crop_word(input int idx, input int ox, input int oy);
        int x;
        int y;
        x = ox + idx % crop_width;
        y = oy + idx / crop_width;
        return {24'h0, frame_pix[y][x]};
    endfunction

    function automatic logic [31:0] ref_metering_word();
        int         sum;
        logic [7:0] peak;
        sum  = 0;
        peak = '0;
        for (int y = 0; y < frame_height; y++) begin
            for (int x = 0; x < frame_width; x++) begin
                sum += int'(frame_pix[y][x]);
                if (frame_pix[y][x] > peak) begin
                    peak = frame_pix[y][x];
                end
            end
        end
        return {16'h0, peak, 8'(sum / (frame_width * frame_height))};   // Mean of whole frame
    endfunction

    task automatic fill_frame();
        for (int y = 0; y < frame_height; y++) begin
            for (int x = 0; x < frame_width; x++) begin
                frame_pix[y][x] = 8'($random(seed));
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        @(posedge mipi_byte_clock);
        mipi_byte_i       <= value;
        mipi_byte_valid_i <= 1'b1;
    endtask

    // One idle cycle models LP-11 between packets
    task automatic end_packet();
        @(posedge mipi_byte_clock);
        mipi_byte_i       <= 8'h00;
        mipi_byte_valid_i <= 1'b0;
    endtask

    task automatic send_header(input logic [5:0] data_type, input logic [15:0] field);
        send_byte({2'b00, data_type});   // Virtual channel 0
        send_byte(field[7:0]);
        send_byte(field[15:8]);
        send_byte(8'h00);                // ECC
    endtask

    task automatic send_line(input int y);
        send_header(dt_raw8, 16'(frame_width));
        for (int x = 0; x < frame_width; x++) begin
            send_byte(frame_pix[y][x]);
        end
        send_byte(8'h00);   // CRC low
        send_byte(8'h00);   // CRC high
        end_packet();
    endtask

    // Bright RAW10 long packet that must stay out of the metering
    task automatic send_other_packet();
        send_header(6'h2B, 16'd16);
        for (int i = 0; i < 16; i++) begin
            send_byte(8'hFF);
        end
        send_byte(8'h00);
        send_byte(8'h00);
        end_packet();
    endtask

    task automatic send_frame(input logic [15:0] number, input bit with_other);
        send_header(dt_frame_start, number);
        end_packet();
        for (int y = 0; y < frame_height; y++) begin
            send_line(y);
            if (with_other && y == 3) begin
                send_other_packet();
            end
        end
        send_header(dt_frame_end, number);
        end_packet();
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
        int waited;
        @(posedge mipi_byte_clock);
        axi_awaddr_i  <= addr;
        axi_awvalid_i <= 1'b1;
        axi_wdata_i   <= data;
        axi_wstrb_i   <= 4'hF;
        axi_wvalid_i  <= 1'b1;
        waited = 0;
        do begin
            @(posedge mipi_byte_clock);
            waited++;
        end while (!axi_awready_o && waited < handshake_limit);
        if (!axi_awready_o) begin
            abort_on_timeout("awready");
        end
        check_value("wready with awready", {31'h0, axi_wready_o}, 32'h1);
        axi_awvalid_i <= 1'b0;
        axi_wvalid_i  <= 1'b0;
        axi_bready_i  <= 1'b1;
        waited = 0;
        do begin
            @(posedge mipi_byte_clock);
            waited++;
        end while (!axi_bvalid_o && waited < handshake_limit);
        if (!axi_bvalid_o) begin
            abort_on_timeout("bvalid");
        end
        check_value("bresp OKAY", {30'h0, axi_bresp_o}, 32'h0);
        axi_bready_i <= 1'b0;
    endtask

    // Stall cycles hold rready low after rvalid rises
    task automatic axi_read(input logic [11:0] addr, input int stall, output logic [31:0] data);
        int waited;
        @(posedge mipi_byte_clock);
        axi_araddr_i  <= addr;
        axi_arvalid_i <= 1'b1;
        waited = 0;
        do begin
            @(posedge mipi_byte_clock);
            waited++;
        end while (!axi_arready_o && waited < handshake_limit);
        if (!axi_arready_o) begin
            abort_on_timeout("arready");
        end
        axi_arvalid_i <= 1'b0;
        axi_rready_i  <= (stall == 0);
        waited = 0;
        do begin
            @(posedge mipi_byte_clock);
            waited++;
        end while (!axi_rvalid_o && waited < handshake_limit);
        if (!axi_rvalid_o) begin
            abort_on_timeout("rvalid");
        end
        data = axi_rdata_o;
        check_value("rresp OKAY", {30'h0, axi_rresp_o}, 32'h0);
        if (stall > 0) begin
            for (int i = 0; i < stall; i++) begin
                @(posedge mipi_byte_clock);
                check_value("rvalid held", {31'h0, axi_rvalid_o}, 32'h1);
                check_value("rdata held", axi_rdata_o, data);
            end
            axi_rready_i <= 1'b1;
            @(posedge mipi_byte_clock);
        end
        axi_rready_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        int          waited;
        mipi_byte_i       <= 8'h00;
        mipi_byte_valid_i <= 1'b0;
        axi_awaddr_i      <= '0;
        axi_awvalid_i     <= 1'b0;
        axi_wdata_i       <= '0;
        axi_wstrb_i       <= '0;
        axi_wvalid_i      <= 1'b0;
        axi_bready_i      <= 1'b0;
        axi_araddr_i      <= '0;
        axi_arvalid_i     <= 1'b0;
        axi_rready_i      <= 1'b0;

        waited = 0;
        do begin
            @(posedge mipi_byte_clock);
            waited++;
        end while (!mipi_byte_reset_n && waited < 20);
        if (!mipi_byte_reset_n) begin
            abort_on_timeout("reset release");
        end

        axi_read(reg_control, 0, rd);
        check_value("control after reset", rd, 32'h0);
        axi_read(reg_origin, 0, rd);
        check_value("origin after reset", rd, 32'h0);
        axi_read(reg_metering, 0, rd);
        check_value("metering after reset", rd, 32'h0);

        axi_write(reg_origin, 32'h0002_0003);   // x = 3, y = 2
        axi_read(reg_origin, 0, rd);
        check_value("origin read back", rd, 32'h0002_0003);

        // Armed capture of a random frame
        fill_frame();
        axi_write(reg_control, 32'h1);
        send_frame(16'h1234, 1'b0);
        waited = 0;
        do begin
            axi_read(reg_control, 0, rd);
            waited++;
        end while (!rd[1] && waited < poll_limit);
        if (!rd[1]) begin
            abort_on_timeout("capture done bit");
        end
        check_value("control after capture", rd, 32'h1234_0002);
        for (int i = 0; i < buf_depth; i++) begin
            first_crop[i] = ref_crop_word(i, 3, 2);
            axi_read(reg_buffer_base + 12'(4 * i), 0, rd);
            check_value("captured pixel", rd, first_crop[i]);
        end
        axi_read(reg_metering, 0, rd);
        check_value("metering first frame", rd, ref_metering_word());

        // Unarmed frame with a foreign long packet inside
        fill_frame();
        send_frame(16'h1235, 1'b1);
        repeat (4) @(posedge mipi_byte_clock);   // Frame end to metering register
        for (int i = 0; i < buf_depth; i++) begin
            axi_read(reg_buffer_base + 12'(4 * i), 0, rd);
            check_value("buffer kept", rd, first_crop[i]);
        end
        axi_read(reg_metering, 0, rd);
        check_value("metering second frame", rd, ref_metering_word());
        axi_read(reg_control, 0, rd);
        check_value("control second frame", rd, 32'h1235_0002);

        axi_read(reg_origin, 6, rd);
        check_value("origin under back-pressure", rd, 32'h0002_0003);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
    parameter int reset_cycles = 8
) (
    output logic mipi_byte_clock_o,
    output logic mipi_byte_reset_n_o
);
    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        mipi_byte_clock_o = 1'b0;
        forever #50 mipi_byte_clock_o = ~mipi_byte_clock_o;   // 100 ns period
    end

    initial begin
        mipi_byte_reset_n_o = 1'b0;
        repeat (reset_cycles) @(posedge mipi_byte_clock_o);
        mipi_byte_reset_n_o <= 1'b1;   // Released on a rising edge
    end

endmodule

// File: window_crop.sv
module window_crop #(
    parameter  int crop_width  = 8,
    parameter  int crop_height = 4,
    localparam int buf_depth   = crop_width * crop_height,
    localparam int addr_w      = $clog2(buf_depth)
) (
    input  logic              mipi_byte_clock,
    input  logic              mipi_byte_reset_n,
    input  logic              frame_start_i,
    input  logic              line_start_i,
    input  logic              frame_end_i,
    input  logic [7:0]        pixel_i,
    input  logic              pixel_valid_i,
    input  logic [15:0]       origin_x_i,
    input  logic [15:0]       origin_y_i,
    output logic              buf_wr_o,
    output logic [addr_w-1:0] buf_addr_o,
    output logic [7:0]        buf_data_o,
    output logic              window_done_o
);

    logic [15:0] x_pos;
    logic [15:0] y_pos;
    logic [15:0] rel_x;
    logic [15:0] rel_y;
    logic        line_seen;   // First line of the frame keeps y at zero
    logic        in_window;

    assign rel_x = x_pos - origin_x_i;
    assign rel_y = y_pos - origin_y_i;
    assign in_window = (x_pos >= origin_x_i) && (rel_x < 16'(crop_width)) &&
                       (y_pos >= origin_y_i) && (rel_y < 16'(crop_height));

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_pos         <= '0;
            y_pos         <= '0;
            line_seen     <= 1'b0;
            buf_wr_o      <= 1'b0;
            window_done_o <= 1'b0;
        end else begin
            buf_wr_o      <= pixel_valid_i && in_window;
            window_done_o <= frame_end_i;
            if (frame_start_i) begin
                x_pos     <= '0;
                y_pos     <= '0;
                line_seen <= 1'b0;
            end else if (line_start_i) begin
                x_pos     <= '0;
                line_seen <= 1'b1;
                if (line_seen) begin
                    y_pos <= y_pos + 16'd1;
                end
            end else if (pixel_valid_i) begin
                x_pos <= x_pos + 16'd1;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (pixel_valid_i) begin
            buf_data_o <= pixel_i;
            buf_addr_o <= addr_w'(rel_y * crop_width + rel_x);   // Row major inside window
        end
    end

    // Full address before truncation to the buffer width
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        pixel_valid_i && in_window |-> int'(rel_y) * crop_width + int'(rel_x) < buf_depth);

endmodule
